/* hdl/lcd_defs.svh */
// address map, graph sizes and bus timing constants for the LCD block, include where needed
`ifndef LCD_DEFS_SVH
`define LCD_DEFS_SVH

// read-side register map
`define LCD_INPUT_ADDR   32'h1fd0_c000
`define TOUCH_INPUT_ADDR 32'h1fd0_c004

// fill codes returned on reads
`define TOUCH_CODE       32'hffff_ffff
`define UNMAPPED_CODE    32'heeee_eeee

// store address bit that picks data (1) or command (0)
`define LCD_RS_BIT       2

// one graph is six LCD entries plus the fill count word
`define GRAPH_ENTRIES    6
`define GRAPH_WORDS      7

// 8080 write strobe shape in pclk cycles
`define LCD_WR_LOW       2
`define LCD_WR_HIGH      2

`endif

/* hdl/lcd_pkg.sv */
// shared types of the LCD subsystem, referenced by scoped name from the RTL files
package lcd_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  axi_id_t;
    typedef logic [7:0]  axi_len_t;   // beats minus one
    typedef logic [1:0]  axi_resp_t;
    typedef logic [15:0] pixel_t;     // LCD bus word
    typedef logic [15:0] fill_t;

    // one buffered store
    typedef struct packed {
        addr_t addr;
        word_t data;
    } lcd_cmd_t;

    typedef struct packed {
        axi_id_t  id;
        addr_t    addr;
        axi_len_t len;
        logic [2:0] size;
        logic [1:0] burst;
        logic [1:0] lock;
        logic [3:0] cache;
        logic [2:0] prot;
    } axi_ar_t;

    typedef axi_ar_t axi_aw_t;  // same field set on both address channels

    typedef struct packed {
        word_t      data;
        logic [3:0] strb;
        logic       last;
    } axi_w_t;

    typedef enum logic {RD_ADDR, RD_DATA} rd_state_e;
    typedef enum logic [1:0] {WR_IDLE, WR_ADDR, WR_DATA, WR_RESP} wr_state_e;
    typedef enum logic {BUF_FILL, BUF_DISPATCH} buf_state_e;
    typedef enum logic [1:0] {DEC_IDLE, DEC_ISSUE, DEC_WAIT, DEC_REPEAT} dec_state_e;

endpackage

/* hdl/lcd_axi_slave.sv */
// AXI slave of the LCD block, answers register reads and forwards full-word stores to the buffer
`timescale 1ns/1ps
`include "lcd_defs.svh"

module lcd_axi_slave (
    input  logic               pclk,
    input  logic               rst_n,
    input  lcd_pkg::axi_ar_t   ar,
    input  logic               arvalid,
    output logic               arready,
    output lcd_pkg::axi_id_t   rid,
    output lcd_pkg::word_t     rdata,
    output lcd_pkg::axi_resp_t rresp,
    output logic               rlast,
    output logic               rvalid,
    input  logic               rready,
    input  lcd_pkg::axi_aw_t   aw,
    input  logic               awvalid,
    output logic               awready,
    input  lcd_pkg::axi_w_t    w,
    input  logic               wvalid,
    output logic               wready,
    output lcd_pkg::axi_id_t   bid,
    output lcd_pkg::axi_resp_t bresp,
    output logic               bvalid,
    input  logic               bready,
    input  lcd_pkg::word_t     lcd_input,
    input  logic               buffer_busy,
    output logic               store,
    output lcd_pkg::lcd_cmd_t  store_cmd
);
    lcd_pkg::rd_state_e rd_state;
    lcd_pkg::wr_state_e wr_state;
    lcd_pkg::addr_t     rd_addr;   // latched araddr
    lcd_pkg::addr_t     wr_addr;   // latched awaddr
    logic               w_fire;

    assign rresp = '0;  // OKAY
    assign bresp = '0;

    assign w_fire         = wvalid && wready;
    assign store          = w_fire && (&w.strb);  // partial beats are dropped here
    assign store_cmd.addr = wr_addr;
    assign store_cmd.data = w.data;

    // read side
    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            rd_state <= lcd_pkg::RD_ADDR;
            arready  <= 1'b1;
            rvalid   <= 1'b0;
            rlast    <= 1'b0;
        end else begin
            case (rd_state)
                lcd_pkg::RD_ADDR: begin
                    if (arvalid && arready) begin
                        rd_state <= lcd_pkg::RD_DATA;
                        arready  <= 1'b0;
                    end
                end
                lcd_pkg::RD_DATA: begin
                    if (rvalid && rready) begin
                        rd_state <= lcd_pkg::RD_ADDR;
                        arready  <= 1'b1;
                        rvalid   <= 1'b0;
                        rlast    <= 1'b0;
                    end else begin
                        rvalid <= 1'b1;
                        rlast  <= 1'b1;  // single beat only
                    end
                end
                default: rd_state <= lcd_pkg::RD_ADDR;
            endcase
        end
    end

    always_ff @(posedge pclk) begin
        if (arvalid && arready) begin
            rid     <= ar.id;
            rd_addr <= ar.addr;
        end
        if (rd_state == lcd_pkg::RD_DATA && !rvalid) begin
            case (rd_addr)
                `LCD_INPUT_ADDR:   rdata <= lcd_input;
                `TOUCH_INPUT_ADDR: rdata <= `TOUCH_CODE;  // no touch panel behind it
                default:           rdata <= `UNMAPPED_CODE;
            endcase
        end
    end

    // write side
    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            wr_state <= lcd_pkg::WR_IDLE;
            awready  <= 1'b0;
            wready   <= 1'b0;
            bvalid   <= 1'b0;
        end else begin
            case (wr_state)
                lcd_pkg::WR_IDLE: begin
                    if (!buffer_busy) begin  // hold off the CPU while drawing
                        wr_state <= lcd_pkg::WR_ADDR;
                        awready  <= 1'b1;
                    end
                end
                lcd_pkg::WR_ADDR: begin
                    if (awvalid && awready) begin
                        wr_state <= lcd_pkg::WR_DATA;
                        awready  <= 1'b0;
                        wready   <= 1'b1;
                    end
                end
                lcd_pkg::WR_DATA: begin
                    if (w_fire) begin
                        wr_state <= lcd_pkg::WR_RESP;
                        wready   <= 1'b0;
                        bvalid   <= 1'b1;
                    end
                end
                lcd_pkg::WR_RESP: begin
                    if (bready) begin
                        wr_state <= lcd_pkg::WR_IDLE;
                        bvalid   <= 1'b0;
                    end
                end
                default: wr_state <= lcd_pkg::WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge pclk) begin
        if (awvalid && awready) begin
            bid     <= aw.id;
            wr_addr <= aw.addr;
        end
    end

    // bursts are not supported
    assert property (@(posedge pclk) disable iff (!rst_n)
        arvalid && arready |-> ar.len == '0);
    assert property (@(posedge pclk) disable iff (!rst_n)
        awvalid && awready |-> aw.len == '0);
    assert property (@(posedge pclk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

/* hdl/lcd_graph_buffer.sv */
// graph buffer, collects seven stores and feeds the six LCD entries to the command decoder
`timescale 1ns/1ps
`include "lcd_defs.svh"

module lcd_graph_buffer (
    input  logic              pclk,
    input  logic              rst_n,
    input  logic              store,
    input  lcd_pkg::lcd_cmd_t store_cmd,
    output logic              buffer_busy,
    output logic              cmd_valid,
    output lcd_pkg::lcd_cmd_t cmd,
    output logic              last_entry,
    output lcd_pkg::fill_t    fill,
    input  logic              cmd_ready
);
    localparam int CNT_W = $clog2(`GRAPH_WORDS);

    lcd_pkg::buf_state_e state;
    lcd_pkg::lcd_cmd_t   entries [`GRAPH_WORDS];
    logic [CNT_W-1:0]    count;   // stores taken so far
    logic [CNT_W-1:0]    idx;     // next entry to hand out
    logic                idle_gap;
    logic                send;
    logic                finish;

    // decoder idle and no pulse in flight
    assign idle_gap = (state == lcd_pkg::BUF_DISPATCH) && cmd_ready && !cmd_valid;
    assign send     = idle_gap && (idx != CNT_W'(`GRAPH_ENTRIES));
    assign finish   = idle_gap && (idx == CNT_W'(`GRAPH_ENTRIES));

    always_ff @(posedge pclk) begin
        if (store) begin
            entries[count] <= store_cmd;
        end else if (finish) begin
            for (int i = 0; i < `GRAPH_WORDS; i++) begin
                entries[i] <= '0;
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (send) begin
            cmd        <= entries[idx];
            last_entry <= (idx == CNT_W'(`GRAPH_ENTRIES - 1));
            // seventh word carries the fill count
            fill       <= entries[`GRAPH_WORDS-1].data[$bits(lcd_pkg::fill_t)-1:0];
        end
    end

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            state       <= lcd_pkg::BUF_FILL;
            count       <= '0;
            idx         <= '0;
            buffer_busy <= 1'b0;
            cmd_valid   <= 1'b0;
        end else begin
            cmd_valid <= send;  // one cycle pulse
            case (state)
                lcd_pkg::BUF_FILL: begin
                    if (store) begin
                        count <= count + 1'b1;
                        if (count == CNT_W'(`GRAPH_WORDS - 1)) begin
                            state       <= lcd_pkg::BUF_DISPATCH;
                            count       <= '0;
                            idx         <= '0;
                            buffer_busy <= 1'b1;
                        end
                    end
                end
                lcd_pkg::BUF_DISPATCH: begin
                    if (send) begin
                        idx <= idx + 1'b1;
                    end else if (finish) begin
                        state       <= lcd_pkg::BUF_FILL;  // last entry drawn
                        buffer_busy <= 1'b0;
                    end
                end
                default: state <= lcd_pkg::BUF_FILL;
            endcase
        end
    end

    // the slave must stall writes while a graph is drawn
    assert property (@(posedge pclk) disable iff (!rst_n) store |-> !buffer_busy);

endmodule

/* hdl/lcd_cmd_decoder.sv */
// command decoder, turns buffered entries into LCD bus writes and repeats the last one as fill
`timescale 1ns/1ps
`include "lcd_defs.svh"

module lcd_cmd_decoder (
    input  logic              pclk,
    input  logic              rst_n,
    input  logic              cmd_valid,
    input  lcd_pkg::lcd_cmd_t cmd,
    input  logic              last_entry,
    input  lcd_pkg::fill_t    fill,
    output logic              cmd_ready,
    output logic              bus_write,
    output logic              rs,
    output lcd_pkg::pixel_t   bus_data,
    input  logic              bus_busy
);
    lcd_pkg::dec_state_e state;
    lcd_pkg::fill_t      remaining;  // writes left, current one included

    assign cmd_ready = (state == lcd_pkg::DEC_IDLE);

    always_ff @(posedge pclk) begin
        if (cmd_ready && cmd_valid) begin
            rs       <= cmd.addr[`LCD_RS_BIT];
            bus_data <= cmd.data[$bits(lcd_pkg::pixel_t)-1:0];
        end
    end

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            state     <= lcd_pkg::DEC_IDLE;
            remaining <= '0;
            bus_write <= 1'b0;
        end else begin
            bus_write <= 1'b0;
            case (state)
                lcd_pkg::DEC_IDLE: begin
                    if (cmd_valid) begin
                        state <= lcd_pkg::DEC_ISSUE;
                        if (last_entry && fill != '0) begin
                            remaining <= fill;  // paint the region
                        end else begin
                            remaining <= lcd_pkg::fill_t'(1);
                        end
                    end
                end
                lcd_pkg::DEC_ISSUE: begin
                    bus_write <= 1'b1;
                    state     <= lcd_pkg::DEC_WAIT;
                end
                lcd_pkg::DEC_WAIT: begin
                    // busy shows up one cycle after the strobe
                    if (!bus_write && !bus_busy) begin
                        if (remaining == lcd_pkg::fill_t'(1)) begin
                            state <= lcd_pkg::DEC_IDLE;
                        end else begin
                            state <= lcd_pkg::DEC_REPEAT;
                        end
                    end
                end
                lcd_pkg::DEC_REPEAT: begin
                    remaining <= remaining - 1'b1;
                    state     <= lcd_pkg::DEC_ISSUE;
                end
                default: state <= lcd_pkg::DEC_IDLE;
            endcase
        end
    end

endmodule

/* hdl/lcd_bus_writer.sv */
// 8080 bus writer, shapes one write cycle on the LCD pins and samples the LCD input pins
`timescale 1ns/1ps
`include "lcd_defs.svh"

module lcd_bus_writer (
    input  logic            pclk,
    input  logic            rst_n,
    input  logic            bus_write,
    input  logic            rs,
    input  lcd_pkg::pixel_t bus_data,
    output logic            bus_busy,
    output logic            lcd_cs_n,
    output logic            lcd_rs,
    output logic            lcd_wr_n,
    output lcd_pkg::pixel_t lcd_data,
    input  lcd_pkg::pixel_t lcd_din,
    output lcd_pkg::word_t  lcd_input
);
    localparam int CYCLE_LEN = `LCD_WR_LOW + `LCD_WR_HIGH;
    localparam int PHASE_W   = $clog2(CYCLE_LEN);

    logic [PHASE_W-1:0] phase;
    lcd_pkg::pixel_t    din_meta;
    lcd_pkg::pixel_t    din_sync;

    // two-flop synchronizer on the input pins
    always_ff @(posedge pclk) begin
        din_meta <= lcd_din;
        din_sync <= din_meta;
    end

    assign lcd_input = lcd_pkg::word_t'(din_sync);  // zero extended

    always_ff @(posedge pclk) begin
        if (bus_write) begin
            lcd_rs   <= rs;
            lcd_data <= bus_data;  // held for the whole cycle
        end
    end

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            bus_busy <= 1'b0;
            phase    <= '0;
            lcd_cs_n <= 1'b1;
            lcd_wr_n <= 1'b1;
        end else if (bus_write) begin
            bus_busy <= 1'b1;
            phase    <= '0;
            lcd_cs_n <= 1'b0;
            lcd_wr_n <= 1'b0;
        end else if (bus_busy) begin
            phase <= phase + 1'b1;
            if (phase == PHASE_W'(`LCD_WR_LOW - 1)) begin
                lcd_wr_n <= 1'b1;  // LCD latches on this edge
            end
            if (phase == PHASE_W'(CYCLE_LEN - 1)) begin
                bus_busy <= 1'b0;
                lcd_cs_n <= 1'b1;
                phase    <= '0;
            end
        end
    end

    // decoder must wait for the previous cycle
    assert property (@(posedge pclk) disable iff (!rst_n) bus_write |-> !bus_busy);

endmodule

/* hdl/lcd_top.sv */
// LCD subsystem top, AXI slave port on one side and the 8080 LCD pins on the other
`timescale 1ns/1ps

module lcd_top (
    input  logic               pclk,
    input  logic               rst_n,
    input  lcd_pkg::axi_ar_t   ar,
    input  logic               arvalid,
    output logic               arready,
    output lcd_pkg::axi_id_t   rid,
    output lcd_pkg::word_t     rdata,
    output lcd_pkg::axi_resp_t rresp,
    output logic               rlast,
    output logic               rvalid,
    input  logic               rready,
    input  lcd_pkg::axi_aw_t   aw,
    input  logic               awvalid,
    output logic               awready,
    input  lcd_pkg::axi_w_t    w,
    input  logic               wvalid,
    output logic               wready,
    output lcd_pkg::axi_id_t   bid,
    output lcd_pkg::axi_resp_t bresp,
    output logic               bvalid,
    input  logic               bready,
    output logic               lcd_cs_n,
    output logic               lcd_rs,
    output logic               lcd_wr_n,
    output lcd_pkg::pixel_t    lcd_data,
    input  lcd_pkg::pixel_t    lcd_din
);
    // slave to buffer
    logic              store;
    lcd_pkg::lcd_cmd_t store_cmd;
    logic              buffer_busy;
    // buffer to decoder
    logic              cmd_valid;
    lcd_pkg::lcd_cmd_t cmd;
    logic              last_entry;
    lcd_pkg::fill_t    fill;
    logic              cmd_ready;
    // decoder to bus writer
    logic              bus_write;
    logic              rs;
    lcd_pkg::pixel_t   bus_data;
    logic              bus_busy;
    lcd_pkg::word_t    lcd_input;  // sampled pins back to the read path

    lcd_axi_slave u_slave (.*);

    lcd_graph_buffer u_buffer (.*);

    lcd_cmd_decoder u_decoder (.*);

    lcd_bus_writer u_writer (.*);

endmodule

/* dv/lcd_tb_clk.sv */
// testbench clock and reset source, 10 ns pclk with rst_n held low for the first 10 cycles
`timescale 1ns/1ps

module lcd_tb_clk (
    output logic pclk,
    output logic rst_n
);
    initial begin
        pclk = 1'b0;
        forever #5 pclk = ~pclk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge pclk);
        #1 rst_n = 1'b1;  // released off the edge like every other input
    end

endmodule

/* dv/lcd_tb.sv */
// directed testbench that drives lcd_top over AXI and checks the LCD bus writes it causes
`timescale 1ns/1ps
`include "lcd_defs.svh"

module lcd_tb;
    localparam int MAX_FILL     = 12;
    localparam int WRITE_CYCLES = 8;   // bus cycle plus decoder turnaround
    localparam int AXI_CYCLES   = 8;
    localparam int NUM_GRAPHS   = 4;
    localparam int GRAPH_CYCLES = (`GRAPH_ENTRIES - 1 + MAX_FILL) * WRITE_CYCLES
                                  + `GRAPH_WORDS * AXI_CYCLES;
    localparam int TIMEOUT_CYCLES = 20 * NUM_GRAPHS * GRAPH_CYCLES + 4000;

    logic pclk;
    logic rst_n;
    lcd_pkg::axi_ar_t   ar;
    logic               arvalid;
    logic               arready;
    lcd_pkg::axi_id_t   rid;
    lcd_pkg::word_t     rdata;
    lcd_pkg::axi_resp_t rresp;
    logic               rlast;
    logic               rvalid;
    logic               rready;
    lcd_pkg::axi_aw_t   aw;
    logic               awvalid;
    logic               awready;
    lcd_pkg::axi_w_t    w;
    logic               wvalid;
    logic               wready;
    lcd_pkg::axi_id_t   bid;
    lcd_pkg::axi_resp_t bresp;
    logic               bvalid;
    logic               bready;
    logic               lcd_cs_n;
    logic               lcd_rs;
    logic               lcd_wr_n;
    lcd_pkg::pixel_t    lcd_data;
    lcd_pkg::pixel_t    lcd_din;

    logic [16:0] seen_q [$];  // {rs, data} per LCD write
    logic [16:0] exp_q [$];
    logic [31:0] rng_state = 32'd57068;
    string       test_name;
    int          errors       = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    int          cycles       = 0;

    lcd_tb_clk u_clk (.pclk(pclk), .rst_n(rst_n));

    lcd_top u_dut (.*);

    // LCD latches on the rising wr_n edge
    always @(posedge lcd_wr_n) begin
        if (rst_n === 1'b1) begin
            check_eq("lcd_cs_n at wr_n rise", 32'd0, 32'(lcd_cs_n));
            seen_q.push_back({lcd_rs, lcd_data});
        end
    end

    always @(posedge pclk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles in %s, a handshake or LCD write never came",
                     cycles, test_name);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check_eq(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAIL %s: %s expected %h, actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic report_test(input int start_errors);
        tests_run++;
        if (errors == start_errors) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errors - start_errors);
        end
    endtask

    task automatic write_request(input logic [31:0] addr, input logic [31:0] data,
                                 input logic [3:0] strb, input logic [3:0] id);
        @(posedge pclk);
        #1;
        aw      = '0;
        aw.id   = id;
        aw.addr = addr;
        awvalid = 1'b1;
        @(posedge pclk);
        while (!awready) @(posedge pclk);
        #1;
        awvalid = 1'b0;
        w.data  = data;
        w.strb  = strb;
        w.last  = 1'b1;
        wvalid  = 1'b1;
        @(posedge pclk);
        while (!wready) @(posedge pclk);
        #1 wvalid = 1'b0;
    endtask

    task automatic wait_bresp(input logic [3:0] id);
        @(posedge pclk);
        while (!(bvalid && bready)) @(posedge pclk);
        check_eq("bid", 32'(id), 32'(bid));
        check_eq("bresp", 32'd0, 32'(bresp));
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic [3:0] id);
        write_request(addr, data, strb, id);
        wait_bresp(id);
    endtask

    task automatic axi_read(input logic [31:0] addr, input logic [3:0] id,
                            output logic [31:0] data);
        @(posedge pclk);
        #1;
        ar      = '0;
        ar.id   = id;
        ar.addr = addr;
        arvalid = 1'b1;
        @(posedge pclk);
        while (!arready) @(posedge pclk);
        #1 arvalid = 1'b0;
        @(posedge pclk);
        while (!(rvalid && rready)) @(posedge pclk);
        data = rdata;
        check_eq("rid", 32'(id), 32'(rid));
        check_eq("rlast", 32'd1, 32'(rlast));
        check_eq("rresp", 32'd0, 32'(rresp));
    endtask

    // six random entries and the fill word with their expected writes queued
    task automatic send_graph(input logic [15:0] fill);
        logic [31:0] addr;
        logic [31:0] data;
        int          reps;
        for (int i = 0; i < `GRAPH_ENTRIES; i++) begin
            addr = next_random() & 32'hffff_fffc;
            data = next_random();
            reps = 1;
            if (i == `GRAPH_ENTRIES - 1 && fill != 16'd0) begin
                reps = int'(fill);
            end
            repeat (reps) exp_q.push_back({addr[`LCD_RS_BIT], data[15:0]});
            axi_write(addr, data, 4'hf, 4'(i));
        end
        addr = next_random() & 32'hffff_fffc;
        data = next_random();
        axi_write(addr, {data[31:16], fill}, 4'hf, 4'h7);
    endtask

    task automatic check_graph();
        int n;
        while (seen_q.size() < exp_q.size()) @(posedge pclk);
        while (!awready) @(posedge pclk);  // buffer released so nothing more comes
        check_eq("LCD write count", 32'(exp_q.size()), 32'(seen_q.size()));
        n = (seen_q.size() < exp_q.size()) ? seen_q.size() : exp_q.size();
        for (int i = 0; i < n; i++) begin
            check_eq($sformatf("LCD write %0d", i), 32'(exp_q[i]), 32'(seen_q[i]));
        end
        seen_q.delete();
        exp_q.delete();
    endtask

    task automatic reset_state();
        int start;
        start     = errors;
        test_name = "reset_state";
        repeat (3) @(posedge pclk);  // still inside reset
        check_eq("awready", 32'd0, 32'(awready));
        check_eq("wready", 32'd0, 32'(wready));
        check_eq("bvalid", 32'd0, 32'(bvalid));
        check_eq("rvalid", 32'd0, 32'(rvalid));
        check_eq("lcd_cs_n", 32'd1, 32'(lcd_cs_n));
        check_eq("lcd_wr_n", 32'd1, 32'(lcd_wr_n));
        check_eq("arready", 32'd1, 32'(arready));
        report_test(start);
    endtask

    task automatic read_map();
        int          start;
        logic [31:0] tmp;
        logic [31:0] data;
        start     = errors;
        test_name = "read_map";
        tmp = next_random();
        @(posedge pclk);
        #1 lcd_din = tmp[15:0];
        repeat (4) @(posedge pclk);  // through the pin synchronizer
        axi_read(`LCD_INPUT_ADDR, 4'h3, data);
        check_eq("lcd input read", {16'h0, tmp[15:0]}, data);
        axi_read(`TOUCH_INPUT_ADDR, 4'h5, data);
        check_eq("touch read", `TOUCH_CODE, data);
        axi_read(32'h1fd0_c008, 4'hc, data);
        check_eq("unmapped read", `UNMAPPED_CODE, data);
        report_test(start);
    endtask

    task automatic graph_draw();
        int          start;
        logic [31:0] tmp;
        start     = errors;
        test_name = "graph_draw";
        tmp = next_random();
        send_graph(16'(tmp % MAX_FILL) + 16'd1);
        check_graph();
        report_test(start);
    endtask

    task automatic partial_strobe();
        int start;
        start     = errors;
        test_name = "partial_strobe";
        axi_write(32'h0000_0004, next_random(), 4'b0111, 4'hb);  // acked, not stored
        send_graph(16'd3);
        check_graph();
        report_test(start);
    endtask

    task automatic busy_backpressure();
        int          start;
        logic [31:0] tmp;
        start     = errors;
        test_name = "busy_backpressure";
        tmp = next_random();
        send_graph(16'(tmp % MAX_FILL) + 16'd1);
        while (seen_q.size() < exp_q.size()) begin
            @(posedge pclk);
            assert (!awready) else begin
                $display("awready went high in %s before the graph finished drawing",
                         test_name);
                errors++;
            end
        end
        check_graph();
        send_graph(16'd0);  // zero fill still draws the last entry once
        check_graph();
        report_test(start);
    endtask

    task automatic response_hold();
        int start;
        start     = errors;
        test_name = "response_hold";
        @(posedge pclk);
        #1 bready = 1'b0;
        write_request(32'h0000_0010, next_random(), 4'hf, 4'h9);
        repeat (6) begin
            @(posedge pclk);
            assert (bvalid && !awready) else begin
                $display("in %s bvalid dropped or awready rose while bready was low",
                         test_name);
                errors++;
            end
        end
        #1 bready = 1'b1;
        wait_bresp(4'h9);
        axi_write(32'h0000_0014, next_random(), 4'hf, 4'ha);
        report_test(start);
    endtask

    initial begin
        ar      = '0;
        arvalid = 1'b0;
        rready  = 1'b1;
        aw      = '0;
        awvalid = 1'b0;
        w       = '0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        lcd_din = '0;
        test_name = "startup";
        reset_state();
        while (rst_n !== 1'b1) @(posedge pclk);
        repeat (2) @(posedge pclk);
        read_map();
        graph_draw();
        partial_strobe();
        busy_backpressure();
        response_hold();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+hdl
hdl/lcd_pkg.sv
hdl/lcd_axi_slave.sv
hdl/lcd_graph_buffer.sv
hdl/lcd_cmd_decoder.sv
hdl/lcd_bus_writer.sv
hdl/lcd_top.sv
dv/lcd_tb_clk.sv
dv/lcd_tb.sv

/* Makefile */
SRCS := $(wildcard hdl/*.sv hdl/*.svh dv/*.sv) project.f

.PHONY: all run clean

all: obj_dir/Vlcd_tb

obj_dir/Vlcd_tb: $(SRCS)
	verilator --binary --timing --assert -j 0 -f project.f --top-module lcd_tb

run: obj_dir/Vlcd_tb
	@out="$$(./obj_dir/Vlcd_tb)"; echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir
